/* tb.f */
+incdir+design
design/sr_pkg.sv
design/sr_pipe.sv
design/sr_slot_regs.sv
design/sr_resp_combiner.sv
design/sr_fabric_top.sv
testbench/sr_fabric_asserts.sv
testbench/tb_sr_fabric.sv

/* Bender.yml */
package:
  name: sr_fabric

sources:
  - include_dirs:
      - design
    files:
      - design/sr_pkg.sv
      - design/sr_pipe.sv
      - design/sr_slot_regs.sv
      - design/sr_resp_combiner.sv
      - design/sr_fabric_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - testbench/sr_fabric_asserts.sv
      - testbench/tb_sr_fabric.sv

/* testbench/tb_sr_fabric.sv */
`timescale 1ns/1ps

`include "sr_defs.svh"

module tb_sr_fabric;

	logic             global_clk;
	logic             global_rst_n;
	logic             req_valid;
	logic             req_is_write;
	sr_pkg::sr_addr_t req_addr;
	sr_pkg::sr_data_t req_data;
	logic             resp_valid;
	sr_pkg::sr_data_t resp_data;

	int               cycle_cnt = 0;
	logic [15:0]      lfsr_state = 16'd33646;
	sr_pkg::sr_data_t model_regs [8];
	sr_pkg::sr_data_t exp_data_q [$];
	int               exp_due_q [$];
	int               data_errors = 0;
	int               cycle_errors = 0;
	int               protocol_errors = 0;

	sr_fabric_top sr_fabric_top_inst (.*);

	initial begin
		global_clk = 1'b0;
		forever #4 global_clk = ~global_clk;
	end

	always @(posedge global_clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// --------------------------------------------------
	// Reference model and random source
	// --------------------------------------------------

	// Flat index slot*4 + reg, or -1 for an unmapped address
	function automatic int ref_index(input sr_pkg::sr_addr_t addr);
		if (addr[31:6] != '0 || addr[2:0] != '0) begin
			return -1;
		end
		return int'(addr[5:3]);
	endfunction

	function automatic bit ref_read(input sr_pkg::sr_addr_t addr, output sr_pkg::sr_data_t value);
		int idx;
		idx = ref_index(addr);
		value = '0;
		if (idx < 0) begin
			return 1'b0;
		end
		value = model_regs[idx];
		return 1'b1;
	endfunction

	// Galois LFSR, one step per bit
	function automatic logic [63:0] take_bits(input int n);
		logic [63:0] value;
		logic        out_bit;
		value = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit) begin
				lfsr_state = lfsr_state ^ 16'hB400;
			end
			value = {value[62:0], out_bit};
		end
		return value;
	endfunction

	function automatic sr_pkg::sr_addr_t reg_addr(input int idx);
		return sr_pkg::sr_addr_t'(idx) << `SR_REG_LSB;
	endfunction

	// --------------------------------------------------
	// Compare tasks and compare process
	// --------------------------------------------------

	task automatic compare_data(input sr_pkg::sr_data_t got, input sr_pkg::sr_data_t exp);
		if (got !== exp) begin
			data_errors++;
			$display("error at %0t ns: read data %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic compare_cycle(input int got, input int exp);
		if (got != exp) begin
			cycle_errors++;
			$display("error at %0t ns: response in cycle %0d, expected cycle %0d", $time, got, exp);
		end
	endtask

	always @(posedge global_clk) begin
		int edge_now;
		edge_now = cycle_cnt + 1;
		if (!global_rst_n) begin
			if (resp_valid === 1'b1) begin
				if (exp_data_q.size() == 0) begin
					protocol_errors++;
					$display("A response arrived at %0t ns while no read was outstanding", $time);
				end else begin
					compare_data(resp_data, exp_data_q.pop_front());
					compare_cycle(edge_now, exp_due_q.pop_front());
				end
			end else if (exp_due_q.size() > 0 && exp_due_q[0] <= edge_now) begin
				protocol_errors++;
				$display("A read due in cycle %0d got no response", exp_due_q[0]);
				void'(exp_data_q.pop_front());
				void'(exp_due_q.pop_front());
			end
		end
	end

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------

	task automatic issue(input bit is_write, input sr_pkg::sr_addr_t addr,
		input sr_pkg::sr_data_t data);
		sr_pkg::sr_data_t exp;
		int               idx;
		@(posedge global_clk);
		req_valid    <= 1'b1;
		req_is_write <= is_write;
		req_addr     <= addr;
		req_data     <= data;
		idx = ref_index(addr);
		if (is_write) begin
			if (idx >= 0) begin
				model_regs[idx] = data;
			end
		end else if (ref_read(addr, exp)) begin
			// Sampled on the next edge, answered 7 cycles later
			exp_data_q.push_back(exp);
			exp_due_q.push_back(cycle_cnt + 2 + `SR_READ_LATENCY);
		end
	endtask

	task automatic release_bus();
		@(posedge global_clk);
		req_valid    <= 1'b0;
		req_is_write <= 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (exp_due_q.size() > 0 && n < limit) begin
			@(posedge global_clk);
			n++;
		end
		if (exp_due_q.size() > 0) begin
			protocol_errors++;
			$display("Timed out with %0d reads still outstanding", exp_due_q.size());
		end
	endtask

	task automatic read_all();
		for (int i = 0; i < 8; i++) begin
			issue(1'b0, reg_addr(i), '0);
		end
		release_bus();
		wait_drain(`SR_READ_LATENCY + 20);
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------

	initial begin
		sr_pkg::sr_addr_t addr;
		sr_pkg::sr_data_t data;
		sr_pkg::sr_addr_t unmapped [5];
		int               errors;
		int               asrt_fails;
		req_valid    = 1'b0;
		req_is_write = 1'b0;
		req_addr     = '0;
		req_data     = '0;
		global_rst_n = 1'b1;
		for (int i = 0; i < 8; i++) begin
			model_regs[i] = '0;
		end
		repeat (8) @(posedge global_clk);
		global_rst_n <= 1'b0;

		// All registers clear after reset
		read_all();

		// Write slot 0 reg 2, slot 1 reg 2 must stay zero
		issue(1'b1, reg_addr(2), 64'h0123_4567_89AB_CDEF);
		issue(1'b0, reg_addr(2), '0);
		issue(1'b0, reg_addr(6), '0);
		release_bus();
		wait_drain(`SR_READ_LATENCY + 20);

		// Back-to-back reads in scrambled order across both slots
		for (int i = 0; i < 8; i++) begin
			issue(1'b1, reg_addr(i), take_bits(64));
		end
		issue(1'b0, reg_addr(5), '0);
		issue(1'b0, reg_addr(2), '0);
		issue(1'b0, reg_addr(7), '0);
		issue(1'b0, reg_addr(0), '0);
		issue(1'b0, reg_addr(3), '0);
		issue(1'b0, reg_addr(6), '0);
		issue(1'b0, reg_addr(1), '0);
		issue(1'b0, reg_addr(4), '0);
		release_bus();
		wait_drain(`SR_READ_LATENCY + 20);

		// Unmapped traffic, no responses and no register changes
		unmapped[0] = 32'h0000_0040;
		unmapped[1] = 32'h8000_0000;
		unmapped[2] = 32'h0000_0004;
		unmapped[3] = 32'h0001_0008;
		unmapped[4] = 32'h0000_003F;
		foreach (unmapped[i]) begin
			issue(1'b1, unmapped[i], take_bits(64));
			issue(1'b0, unmapped[i], '0);
		end
		release_bus();
		repeat (`SR_READ_LATENCY + 4) @(posedge global_clk);
		read_all();

		// Random mix, with reads right behind writes now and then
		for (int n = 0; n < 300; n++) begin
			addr = reg_addr(int'(take_bits(3)));
			if (take_bits(3) == 0) begin
				if (take_bits(1)) begin
					addr = addr | (32'h1 << (6 + int'(take_bits(4))));
				end else begin
					addr = addr | 32'h4;
				end
			end
			if (take_bits(1)) begin
				data = take_bits(64);
				issue(1'b1, addr, data);
				if (take_bits(2) == 0) begin
					issue(1'b0, addr, '0);
				end
			end else begin
				issue(1'b0, addr, '0);
			end
			if (take_bits(2) == 0) begin
				release_bus();
			end
		end
		release_bus();
		wait_drain(`SR_READ_LATENCY + 40);
		read_all();

		repeat (4) @(posedge global_clk);
		asrt_fails = int'(sr_fabric_top_inst.sr_resp_combiner_inst.sr_fabric_asserts_inst.fail_count);
		errors = data_errors + cycle_errors + protocol_errors + asrt_fails;
		$display("Error counts: data %0d, timing %0d, protocol %0d, assertions %0d",
			data_errors, cycle_errors, protocol_errors, asrt_fails);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* testbench/sr_fabric_asserts.sv */
`timescale 1ns/1ps

module sr_fabric_asserts (
	input logic             global_clk,
	input logic             global_rst_n,
	input logic             resp_valid_0,
	input sr_pkg::sr_data_t resp_data_0,
	input logic             resp_valid_1,
	input sr_pkg::sr_data_t resp_data_1
);

	// Read back by the testbench at the end of the run
	int unsigned fail_count = 0;

	// Slots decode disjoint ranges, so only one may answer per cycle
	slot_resp_exclusive: assert property (@(posedge global_clk) disable iff (global_rst_n)
		!(resp_valid_0 && resp_valid_1))
		else begin
			fail_count++;
			$error("both slots drove a response in the same cycle");
		end

	// Idle slot data must be zero for the OR merge
	slot_0_idle_zero: assert property (@(posedge global_clk) disable iff (global_rst_n)
		!resp_valid_0 |-> (resp_data_0 == '0))
		else begin
			fail_count++;
			$error("slot 0 data is not zero while its valid is low");
		end

	slot_1_idle_zero: assert property (@(posedge global_clk) disable iff (global_rst_n)
		!resp_valid_1 |-> (resp_data_1 == '0))
		else begin
			fail_count++;
			$error("slot 1 data is not zero while its valid is low");
		end

endmodule

bind sr_resp_combiner sr_fabric_asserts sr_fabric_asserts_inst (.*);

/* design/sr_fabric_top.sv */
`timescale 1ns/1ps

`include "sr_defs.svh"

module sr_fabric_top (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  logic             req_valid,
	input  logic             req_is_write,
	input  sr_pkg::sr_addr_t req_addr,
	input  sr_pkg::sr_data_t req_data,
	output logic             resp_valid,
	output sr_pkg::sr_data_t resp_data
);

	// --------------------------------------------------
	// Request path
	// --------------------------------------------------

	logic [`SR_REQ_W-1:0] host_req_bundle;
	logic [`SR_REQ_W-1:0] slot_req_bundle;

	logic                 slot_req_valid;
	logic                 slot_req_is_write;
	sr_pkg::sr_addr_t     slot_req_addr;
	sr_pkg::sr_data_t     slot_req_data;

	assign host_req_bundle = {req_valid, req_is_write, req_addr, req_data};

	sr_pipe #(
		.WIDTH(`SR_REQ_W),
		.STAGES(`SR_PIPE_STAGES)
	) sr_pipe_req_inst (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.in_bus(host_req_bundle),
		.out_bus(slot_req_bundle)
	);

	// Both slots see the same request, each one decodes for itself
	assign {slot_req_valid, slot_req_is_write, slot_req_addr, slot_req_data} = slot_req_bundle;

	// --------------------------------------------------
	// Slots
	// --------------------------------------------------

	logic             slot_resp_valid_0;
	logic             slot_resp_valid_1;
	sr_pkg::sr_data_t slot_resp_data_0;
	sr_pkg::sr_data_t slot_resp_data_1;

	sr_slot_regs #(
		.slot_id(1'b0)
	) sr_slot_regs_0_inst (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.req_valid(slot_req_valid),
		.req_is_write(slot_req_is_write),
		.req_addr(slot_req_addr),
		.req_data(slot_req_data),
		.resp_valid(slot_resp_valid_0),
		.resp_data(slot_resp_data_0)
	);

	sr_slot_regs #(
		.slot_id(1'b1)
	) sr_slot_regs_1_inst (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.req_valid(slot_req_valid),
		.req_is_write(slot_req_is_write),
		.req_addr(slot_req_addr),
		.req_data(slot_req_data),
		.resp_valid(slot_resp_valid_1),
		.resp_data(slot_resp_data_1)
	);

	// --------------------------------------------------
	// Response path
	// --------------------------------------------------

	logic                  merged_resp_valid;
	sr_pkg::sr_data_t      merged_resp_data;
	logic [`SR_RESP_W-1:0] merged_resp_bundle;
	logic [`SR_RESP_W-1:0] host_resp_bundle;

	sr_resp_combiner sr_resp_combiner_inst (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.resp_valid_0(slot_resp_valid_0),
		.resp_data_0(slot_resp_data_0),
		.resp_valid_1(slot_resp_valid_1),
		.resp_data_1(slot_resp_data_1),
		.resp_valid(merged_resp_valid),
		.resp_data(merged_resp_data)
	);

	assign merged_resp_bundle = {merged_resp_valid, merged_resp_data};

	sr_pipe #(
		.WIDTH(`SR_RESP_W),
		.STAGES(`SR_PIPE_STAGES)
	) sr_pipe_resp_inst (
		.global_clk(global_clk),
		.global_rst_n(global_rst_n),
		.in_bus(merged_resp_bundle),
		.out_bus(host_resp_bundle)
	);

	// Back to the host as a strobe plus data
	assign {resp_valid, resp_data} = host_resp_bundle;

endmodule

/* design/sr_resp_combiner.sv */
`timescale 1ns/1ps

module sr_resp_combiner (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  logic             resp_valid_0,
	input  sr_pkg::sr_data_t resp_data_0,
	input  logic             resp_valid_1,
	input  sr_pkg::sr_data_t resp_data_1,
	output logic             resp_valid,
	output sr_pkg::sr_data_t resp_data
);

	// --------------------------------------------------
	// Level 1, one register per slot
	// --------------------------------------------------

	logic             valid_0_q;
	logic             valid_1_q;
	sr_pkg::sr_data_t data_0_q;
	sr_pkg::sr_data_t data_1_q;

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			valid_0_q <= 1'b0;
			valid_1_q <= 1'b0;
			data_0_q  <= '0;
			data_1_q  <= '0;
		end else begin
			valid_0_q <= resp_valid_0;
			valid_1_q <= resp_valid_1;
			data_0_q  <= resp_data_0;
			data_1_q  <= resp_data_1;
		end
	end

	// --------------------------------------------------
	// Level 2, OR merge
	// --------------------------------------------------

	// Slots decode disjoint ranges and idle data is zero,
	// so a plain OR picks the one live response
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			resp_valid <= 1'b0;
			resp_data  <= '0;
		end else begin
			resp_valid <= valid_0_q | valid_1_q;
			resp_data  <= data_0_q | data_1_q;
		end
	end

endmodule

/* design/sr_slot_regs.sv */
`timescale 1ns/1ps

`include "sr_defs.svh"

module sr_slot_regs #(
	parameter sr_pkg::sr_slot_id_t slot_id = '0
) (
	input  logic                global_clk,
	input  logic                global_rst_n,
	input  logic                req_valid,
	input  logic                req_is_write,
	input  sr_pkg::sr_addr_t    req_addr,
	input  sr_pkg::sr_data_t    req_data,
	output logic                resp_valid,
	output sr_pkg::sr_data_t    resp_data
);

	// --------------------------------------------------
	// Address decode
	// --------------------------------------------------

	logic                addr_mapped;
	logic                slot_hit;
	logic                wr_hit;
	logic                rd_hit;
	sr_pkg::sr_reg_idx_t reg_idx;

	// Scratch bank
	sr_pkg::sr_data_t    regs_q [`SR_REGS_PER_SLOT];

	// Upper bits and byte offset must both be zero
	assign addr_mapped = (req_addr[`SR_ADDR_W-1:`SR_SLOT_BIT+1] == '0) &&
		(req_addr[`SR_REG_LSB-1:0] == '0);

	assign slot_hit = req_valid && addr_mapped && (req_addr[`SR_SLOT_BIT] == slot_id);

	assign wr_hit = slot_hit && req_is_write;
	assign rd_hit = slot_hit && !req_is_write;

	// 8-byte words, so the index starts at bit 3
	assign reg_idx = req_addr[`SR_REG_LSB +: $bits(sr_pkg::sr_reg_idx_t)];

	// --------------------------------------------------
	// Register bank
	// --------------------------------------------------

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			for (int i = 0; i < `SR_REGS_PER_SLOT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wr_hit) begin
			// New value visible to a read one cycle later
			regs_q[reg_idx] <= req_data;
		end
	end

	// --------------------------------------------------
	// Read response
	// --------------------------------------------------

	// Data held at zero when idle so the combiner can OR slots together
	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			resp_valid <= 1'b0;
			resp_data  <= '0;
		end else begin
			resp_valid <= rd_hit;
			if (rd_hit) begin
				resp_data <= regs_q[reg_idx];
			end else begin
				resp_data <= '0;
			end
		end
	end

endmodule

/* design/sr_pipe.sv */
`timescale 1ns/1ps

module sr_pipe #(
	parameter int WIDTH = 8,
	parameter int STAGES = 2
) (
	input  logic             global_clk,
	input  logic             global_rst_n,
	input  logic [WIDTH-1:0] in_bus,
	output logic [WIDTH-1:0] out_bus
);

	// --------------------------------------------------
	// Delay line
	// --------------------------------------------------

	// Stage 0 takes the input, last stage drives the output
	logic [WIDTH-1:0] stage_q [STAGES];

	always_ff @(posedge global_clk) begin
		if (global_rst_n) begin
			// Clear every stage so no stale strobe leaks out
			for (int i = 0; i < STAGES; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_bus;
			for (int i = 1; i < STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// STAGES cycles from in_bus to out_bus
	assign out_bus = stage_q[STAGES-1];

endmodule

/* design/sr_pkg.sv */
`include "sr_defs.svh"

package sr_pkg;

	// --------------------------------------------------
	// Vector types
	// --------------------------------------------------

	// Request address as seen by the host
	typedef logic [`SR_ADDR_W-1:0] sr_addr_t;

	// One scratch register word
	typedef logic [`SR_DATA_W-1:0] sr_data_t;

	// Register index inside one slot, address bits 4..3
	typedef logic [$clog2(`SR_REGS_PER_SLOT)-1:0] sr_reg_idx_t;

	// Slot number, taken from address bit 5
	typedef logic [$clog2(`SR_NUM_SLOTS)-1:0] sr_slot_id_t;

endpackage

/* design/sr_defs.svh */
`ifndef SR_DEFS_SVH
`define SR_DEFS_SVH

// Bus widths
`define SR_ADDR_W 32
`define SR_DATA_W 64

// Pipeline depth on both the request and the response side
`define SR_PIPE_STAGES 2

// Slot layout
`define SR_NUM_SLOTS 2
`define SR_REGS_PER_SLOT 4
`define SR_REG_LSB 3
`define SR_SLOT_BIT 5

// Packed bundles as {valid, write, addr, data} and {valid, data}
`define SR_REQ_W (1 + 1 + `SR_ADDR_W + `SR_DATA_W)
`define SR_RESP_W (1 + `SR_DATA_W)

// Request pipe + slot + combiner + response pipe
`define SR_READ_LATENCY 7

`endif
